/* include/bp_defines.svh */
// sizes are fixed for a 4-lane, 256-entry table; changing one macro means checking all the others
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// instruction address width
`define BP_PC_W 32
// byte offset bits inside one instruction
`define BP_INST_OFS 2

// fetch lanes, one counter bank per lane
`define BP_LANES 4
`define BP_LANES_LOG 2

// whole table, 256 counters
`define BP_TABLE_LOG 8

// rows in each bank
`define BP_ROWS 64
`define BP_ROW_LOG 6

// weakly taken
`define BP_INIT_CTR 2

`endif

/* logic/bpPkg.sv */
// shared types only; widths come from bp_defines.svh, which must be on the include path
`include "bp_defines.svh"

package bpPkg;

  // instruction address
  typedef logic [`BP_PC_W-1:0] pcT;

  // row inside one bank
  typedef logic [`BP_ROW_LOG-1:0] rowT;

  // bank number, same as lane number
  typedef logic [`BP_LANES_LOG-1:0] bankT;

  // 2-bit saturating counter, msb is the direction
  typedef logic [1:0] ctrT;

  // one bit per fetch lane
  typedef logic [`BP_LANES-1:0] laneMaskT;

  // table init sequence
  typedef enum logic [1:0] {initStart, initRun, initDone} initStateT;

endpackage

/* logic/tableWrIfc.sv */
// training write path; a strobe with no back-pressure, ignored by the banks while init runs
`timescale 1ns/1ps

interface tableWrIfc
  import bpPkg::*;
  ();

  // target row inside the selected bank
  rowT  wrRow;
  // new counter value
  ctrT  wrCtr;
  // bank picked from the low entry bits
  bankT wrBank;
  // single-cycle write strobe
  logic wrEn;

  // update side drives everything
  modport src (output wrRow, output wrCtr, output wrBank, output wrEn);

  // banks only sample
  modport dst (input wrRow, input wrCtr, input wrBank, input wrEn);

endinterface

/* logic/initFsm.sv */
// init sequencer; ready rises 65 edges after resetRams_i falls and holds until the next reset
`timescale 1ns/1ps

module initFsm
  import bpPkg::*;
  (
  input  logic clk,
  input  logic resetRams_i,
  input  logic ctrLast_i,
  output logic ctrClear_o,
  output logic ctrStep_o,
  output logic initBusy_o,
  output logic ramReady_o
  );

  initStateT state;
  initStateT nextState;

  // state register, async reset back to the start
  always_ff @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
      state <= initStart;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      // one edge to clear the row counter
      initStart:
        nextState = initRun;
      // leave once the last row has been written
      initRun:
        if (ctrLast_i)
          nextState = initDone;
      default:
        nextState = initDone;
    endcase
  end

  // row counter control
  assign ctrClear_o = (state == initStart);
  assign ctrStep_o  = (state == initRun);

  // banks write the init value only while running
  assign initBusy_o = (state == initRun);
  assign ramReady_o = (state == initDone);

endmodule

/* logic/initAddrCounter.sv */
// row counter for init; wraps past the last row, so the sequencer must stop stepping it there
`timescale 1ns/1ps
`include "bp_defines.svh"

module initAddrCounter
  import bpPkg::*;
  (
  input  logic clk,
  input  logic resetRams_i,
  input  logic clear_i,
  input  logic step_i,
  output rowT  row_o,
  output logic last_o
  );

  // clear wins over step
  always_ff @(posedge clk or posedge resetRams_i)
  begin
    if (resetRams_i)
      row_o <= '0;
    else if (clear_i)
      row_o <= '0;
    else if (step_i)
      row_o <= row_o + rowT'(1);
  end

  // final row of every bank
  assign last_o = (row_o == rowT'(`BP_ROWS - 1));

endmodule

/* logic/counterBanks.sv */
// counter storage has no reset; contents are unknown until the init sequence has run
`timescale 1ns/1ps
`include "bp_defines.svh"

module counterBanks
  import bpPkg::*;
  (
  input  logic                    clk,
  input  logic                    initBusy_i,
  input  rowT                     initRow_i,
  input  rowT  [`BP_LANES-1:0]    rdRow_i,
  output ctrT  [`BP_LANES-1:0]    rdCtr_o,
  tableWrIfc.dst                  wr
  );

  for (genvar b = 0; b < `BP_LANES; b++)
  begin : genBank
    // one bank, BP_ROWS counters
    ctrT  mem [`BP_ROWS];
    logic bankWe;
    rowT  bankRow;
    ctrT  bankData;

    // init writes all banks at once
    // training writes only the addressed bank
    assign bankWe = initBusy_i | (wr.wrEn & (wr.wrBank == bankT'(b)));

    // init owns the port; training strobes during init are dropped
    assign bankRow  = initBusy_i ? initRow_i : wr.wrRow;
    assign bankData = initBusy_i ? ctrT'(`BP_INIT_CTR) : wr.wrCtr;

    always_ff @(posedge clk)
    begin
      if (bankWe)
        mem[bankRow] <= bankData;
    end

    // async read, so a write is visible in the following cycle
    assign rdCtr_o[b] = mem[rdRow_i[b]];
  end

endmodule

/* logic/fetchRotate.sv */
// purely combinational; pc_i high bits above the table index are ignored (no tag, aliasing)
`timescale 1ns/1ps
`include "bp_defines.svh"

module fetchRotate
  import bpPkg::*;
  (
  input  pcT                      pc_i,
  output rowT  [`BP_LANES-1:0]    rdRow_o,
  input  ctrT  [`BP_LANES-1:0]    rdCtr_i,
  output laneMaskT                predDir_o,
  output ctrT  [`BP_LANES-1:0]    predCtr_o
  );

  // table index of lane 0
  logic [`BP_TABLE_LOG-1:0] baseEntry;
  // bank holding lane 0, which is the rotation amount
  bankT startOfs;

  assign baseEntry = pc_i[`BP_INST_OFS +: `BP_TABLE_LOG];
  assign startOfs  = baseEntry[`BP_LANES_LOG-1:0];

  // address side
  // bank b serves lane (b - startOfs) mod lanes
  always_comb
  begin
    bankT                     lane;
    logic [`BP_TABLE_LOG-1:0] entry;
    for (int b = 0; b < `BP_LANES; b++)
    begin
      lane  = bankT'(b) - startOfs;
      // 8-bit add wraps entry 255 into entry 0
      entry = baseEntry + {{(`BP_TABLE_LOG-`BP_LANES_LOG){1'b0}}, lane};
      // lanes past the row end carry into the next row here
      rdRow_o[b] = entry[`BP_TABLE_LOG-1:`BP_LANES_LOG];
    end
  end

  // data side, back into lane order
  always_comb
  begin
    bankT bank;
    for (int l = 0; l < `BP_LANES; l++)
    begin
      bank         = startOfs + bankT'(l);
      predCtr_o[l] = rdCtr_i[bank];
      // taken for 2 and 3
      predDir_o[l] = rdCtr_i[bank][1];
    end
  end

endmodule

/* logic/updateUnit.sv */
// zero-cycle update path; the caller supplies the counter read at fetch, no read-modify-write here
`timescale 1ns/1ps
`include "bp_defines.svh"

module updateUnit
  import bpPkg::*;
  (
  input  pcT            updatePc_i,
  input  logic          updateDir_i,
  input  ctrT           updateCtr_i,
  input  logic          updateEn_i,
  tableWrIfc.src        wr
  );

  // entry bits [9:2], low part picks the bank
  assign wr.wrBank = updatePc_i[`BP_INST_OFS +: `BP_LANES_LOG];
  assign wr.wrRow  = updatePc_i[`BP_INST_OFS + `BP_LANES_LOG +: `BP_ROW_LOG];

  // saturating step toward the resolved direction
  always_comb
  begin
    if (updateDir_i)
      wr.wrCtr = (updateCtr_i == 2'b11) ? updateCtr_i : updateCtr_i + ctrT'(1);
    else
      wr.wrCtr = (updateCtr_i == 2'b00) ? updateCtr_i : updateCtr_i - ctrT'(1);
  end

  // strobe passes straight through
  assign wr.wrEn = updateEn_i;

endmodule

/* logic/branchPredictor.sv */
// predictions are valid only once ramReady_o is high; updates during init are lost
`timescale 1ns/1ps
`include "bp_defines.svh"

module branchPredictor
  import bpPkg::*;
  (
  input  logic                    clk,
  input  logic                    resetRams_i,
  input  pcT                      pc_i,
  input  pcT                      updatePc_i,
  input  logic                    updateDir_i,
  input  ctrT                     updateCtr_i,
  input  logic                    updateEn_i,
  output laneMaskT                predDir_o,
  output ctrT  [`BP_LANES-1:0]    predCtr_o,
  output logic                    ramReady_o
  );

  // init path
  logic ctrLast;
  logic ctrClear;
  logic ctrStep;
  logic initBusy;
  rowT  initRow;

  // read path, bank order
  rowT [`BP_LANES-1:0] rdRow;
  ctrT [`BP_LANES-1:0] rdCtr;

  // training writes
  tableWrIfc tableWr ();

  initFsm uInitFsm (
    .clk         (clk),
    .resetRams_i (resetRams_i),
    .ctrLast_i   (ctrLast),
    .ctrClear_o  (ctrClear),
    .ctrStep_o   (ctrStep),
    .initBusy_o  (initBusy),
    .ramReady_o  (ramReady_o)
  );

  initAddrCounter uInitAddrCounter (
    .clk         (clk),
    .resetRams_i (resetRams_i),
    .clear_i     (ctrClear),
    .step_i      (ctrStep),
    .row_o       (initRow),
    .last_o      (ctrLast)
  );

  counterBanks uCounterBanks (
    .clk        (clk),
    .initBusy_i (initBusy),
    .initRow_i  (initRow),
    .rdRow_i    (rdRow),
    .rdCtr_o    (rdCtr),
    .wr         (tableWr.dst)
  );

  fetchRotate uFetchRotate (
    .pc_i      (pc_i),
    .rdRow_o   (rdRow),
    .rdCtr_i   (rdCtr),
    .predDir_o (predDir_o),
    .predCtr_o (predCtr_o)
  );

  updateUnit uUpdateUnit (
    .updatePc_i  (updatePc_i),
    .updateDir_i (updateDir_i),
    .updateCtr_i (updateCtr_i),
    .updateEn_i  (updateEn_i),
    .wr          (tableWr.src)
  );

endmodule

/* verif/bpClkGen.sv */
// 10 ns clock from time zero; reset is released on a falling edge after resetCycles rising edges
`timescale 1ns/1ps

module bpClkGen
  #(parameter int resetCycles = 16)
  (
  output logic clk_o,
  output logic resetRams_o
  );

  // free-running clock, 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // hold reset, then drop it away from the rising edge
  initial
  begin
    resetRams_o = 1'b1;
    repeat (resetCycles) @(posedge clk_o);
    @(negedge clk_o);
    resetRams_o = 1'b0;
  end

endmodule

/* verif/tbBranchPredictor.sv */
// self-checking bench; table model starts weakly taken, stimulus from an LCG seeded with 24
`timescale 1ns/1ps
`include "bp_defines.svh"

module tbBranchPredictor
  import bpPkg::*;
  ();

  localparam int resetCycles = 16;
  localparam int initCycles  = 65;
  localparam int tableSize   = 1 << `BP_TABLE_LOG;
  localparam int numReads    = 40;
  localparam int numUpdates  = 80;
  localparam int satSteps    = 5;
  // training step is two cycles, each followed by a one-cycle read
  localparam int stimCycles  = initCycles + numReads + 3 * numUpdates + 3 + 6 * satSteps;
  localparam int timeoutNs   = (resetCycles + initCycles + stimCycles + 200) * 10;

  logic                 clk;
  logic                 resetRams;
  pcT                   pc;
  pcT                   updatePc;
  logic                 updateDir;
  ctrT                  updateCtr;
  logic                 updateEn;
  laneMaskT             predDir;
  ctrT [`BP_LANES-1:0]  predCtr;
  logic                 ramReady;

  // expected counter per table entry
  int          model [tableSize];
  int          errCount;
  int unsigned lcgState;
  // strobes sent while init runs
  pcT          initUpdPcs [$];

  bpClkGen #(.resetCycles(resetCycles)) uClkGen (
    .clk_o       (clk),
    .resetRams_o (resetRams)
  );

  branchPredictor i_branchPredictor (
    .clk         (clk),
    .resetRams_i (resetRams),
    .pc_i        (pc),
    .updatePc_i  (updatePc),
    .updateDir_i (updateDir),
    .updateCtr_i (updateCtr),
    .updateEn_i  (updateEn),
    .predDir_o   (predDir),
    .predCtr_o   (predCtr),
    .ramReady_o  (ramReady)
  );

  // upper 16 bits of the LCG state, low bits cycle too fast
  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 16;
  endfunction

  function automatic pcT randomPc();
    int unsigned hi;
    int unsigned lo;
    hi = nextRand();
    lo = nextRand();
    return pcT'((hi << 16) | lo);
  endfunction

  // table index: drop byte offset, keep 8 bits
  function automatic int entryOf(input pcT p);
    return int'((p >> `BP_INST_OFS) & 32'hff);
  endfunction

  // step toward the outcome, stop at 0 and 3
  function automatic int satStep(input int ctr, input logic dir);
    if (dir)
      return (ctr >= 3) ? 3 : ctr + 1;
    else
      return (ctr <= 0) ? 0 : ctr - 1;
  endfunction

  task automatic checkEqual(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (expVal !== actVal)
    begin
      errCount++;
      $display("Error %s: expected %0d, actual %0d", name, expVal, actVal);
    end
  endtask

  // drive a fetch PC, check every lane at the next falling edge
  task automatic readLanes(input pcT fetchPc, input string testName);
    int base;
    int entry;
    int expCtr;
    int l;
    pc = fetchPc;
    @(negedge clk);
    base = entryOf(fetchPc);
    for (l = 0; l < `BP_LANES; l++)
    begin
      // lanes wrap past entry 255
      entry  = (base + l) % tableSize;
      expCtr = model[entry];
      checkEqual($sformatf("%s pc=%h lane%0d ctr", testName, fetchPc, l),
                 32'(expCtr), 32'(predCtr[l]));
      checkEqual($sformatf("%s pc=%h lane%0d dir", testName, fetchPc, l),
                 32'(expCtr >= 2), 32'(predDir[l]));
    end
  endtask

  // fetch the counter, then send it back with the outcome
  task automatic trainEntry(input pcT brPc, input logic dir, input string testName);
    int  entry;
    ctrT readCtr;
    entry = entryOf(brPc);
    pc    = brPc;
    @(negedge clk);
    readCtr = predCtr[0];
    checkEqual({testName, " fetch ctr"}, 32'(model[entry]), 32'(readCtr));
    updatePc  = brPc;
    updateDir = dir;
    updateCtr = readCtr;
    updateEn  = 1'b1;
    @(negedge clk);
    // write landed at the rising edge in between
    updateEn     = 1'b0;
    model[entry] = satStep(model[entry], dir);
  endtask

  initial
  begin
    int          k;
    int unsigned r;
    pcT          p;
    errCount  = 0;
    lcgState  = 24;
    pc        = '0;
    updatePc  = '0;
    updateDir = 1'b0;
    updateCtr = '0;
    updateEn  = 1'b0;
    for (k = 0; k < tableSize; k++)
      model[k] = 2;

    // not ready while reset is held
    repeat (resetCycles / 2)
    begin
      @(negedge clk);
      checkEqual("ready in reset", 32'(0), 32'(ramReady));
    end
    @(negedge resetRams);

    // ready only after edge 65; strobes meanwhile would write 0
    for (k = 1; k <= initCycles; k++)
    begin
      p = randomPc();
      initUpdPcs.push_back(p);
      pc        = randomPc();
      updatePc  = p;
      updateDir = 1'b0;
      updateCtr = 2'd1;
      updateEn  = 1'b1;
      @(posedge clk);
      @(negedge clk);
      checkEqual($sformatf("ready after edge %0d", k), 32'(k == initCycles), 32'(ramReady));
    end
    updateEn = 1'b0;

    // entries hit during init still hold weakly taken
    foreach (initUpdPcs[i])
    begin
      readLanes(initUpdPcs[i], "init update");
      checkEqual("init update entry", 32'(2), 32'(predCtr[0]));
    end

    // untouched table reads 2 and taken everywhere
    for (k = 0; k < numReads; k++)
    begin
      readLanes(randomPc(), "init value");
      checkEqual("ready holds", 32'(1), 32'(ramReady));
    end

    // random training, half of it packed into entries 240 to 255
    for (k = 0; k < numUpdates; k++)
    begin
      r = nextRand();
      p = randomPc();
      if (r[3])
        p[9:6] = 4'hf;
      trainEntry(p, r[0], "train");
      // read so the trained entry lands on lane 0 to 3
      readLanes(pcT'(p - ((r >> 1) % 4) * 4), "after train");
    end

    // starts at 253, 254 and 255 wrap into entry 0
    for (k = 0; k < 3; k++)
    begin
      p      = randomPc();
      p[9:2] = 8'(253 + k);
      readLanes(p, "wrap");
    end

    // saturate low, then high
    p = randomPc();
    for (k = 0; k < satSteps; k++)
    begin
      trainEntry(p, 1'b0, "sat down");
      readLanes(p, "sat down");
    end
    checkEqual("sat low", 32'(0), 32'(predCtr[0]));
    for (k = 0; k < satSteps; k++)
    begin
      trainEntry(p, 1'b1, "sat up");
      readLanes(p, "sat up");
    end
    checkEqual("sat high", 32'(3), 32'(predCtr[0]));

    $display("checks failed: %0d", errCount);
    if (errCount == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog sized from reset, init and stimulus lengths
  initial
  begin
    #(timeoutNs);
    $display("Timeout: the run did not finish within %0d ns", timeoutNs);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
logic/bpPkg.sv
logic/tableWrIfc.sv
logic/initFsm.sv
logic/initAddrCounter.sv
logic/counterBanks.sv
logic/fetchRotate.sv
logic/updateUnit.sv
logic/branchPredictor.sv
verif/bpClkGen.sv
verif/tbBranchPredictor.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f vlog.f \
  --top-module tbBranchPredictor \
  -o simBranchPredictor

simOut="$(./obj_dir/simBranchPredictor)"
echo "$simOut"

if echo "$simOut" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
